// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes, bits 6:0
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // load widths
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;
    localparam logic [2:0] F3_SW  = 3'b010; // stores
    localparam logic [2:0] F3_SD  = 3'b011;
    localparam logic [2:0] F3_ADD = 3'b000; // alu, shared by imm and reg forms
    localparam logic [2:0] F3_SLL = 3'b001;
    localparam logic [2:0] F3_SRL = 3'b101;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_BEQ = 3'b000;

    localparam logic [6:0]  F7_SUB    = 7'b0100000;
    localparam logic [31:0] MRET_WORD = 32'h3020_0073;
    localparam logic [31:0] NOP_WORD  = 32'h0000_0013; // addi x0,x0,0

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcode_e    opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;   // bits 5:0 double as shamt
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcode_e     opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        opcode_e    opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_e    opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_e     opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        opcode_e    opcode;
    } j_fmt_t;

    // one fetched word, viewed per format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } rv_instr_u;

    // sign extended immediates
    function automatic logic [63:0] imm_i_of(rv_instr_u w);
        return {{52{w.i.imm[11]}}, w.i.imm};
    endfunction

    function automatic logic [63:0] imm_s_of(rv_instr_u w);
        return {{52{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
    endfunction

    function automatic logic [63:0] imm_b_of(rv_instr_u w);
        return {{51{w.b.imm_12}}, w.b.imm_12, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
    endfunction

    function automatic logic [63:0] imm_u_of(rv_instr_u w);
        return {{32{w.u.imm[19]}}, w.u.imm, 12'b0};
    endfunction

    function automatic logic [63:0] imm_j_of(rv_instr_u w);
        return {{43{w.j.imm_20}}, w.j.imm_20, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
    endfunction

endpackage

// File: logic/rv_core_pkg.sv
package rv_core_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;
    localparam int BUS_DATA_W = 32; // data bus moves one word per strobe

    localparam logic [XLEN-1:0] RAM_BASE    = 64'h0000_0000_0000_1000; // reset pc
    localparam logic [XLEN-1:0] TRAP_VECTOR = 64'h0000_0000_0000_0100; // fixed handler entry

    localparam logic [3:0] IRQ_EXTERNAL = 4'd1; // machine external interrupt request

    typedef logic [XLEN-1:0] word_t;

    // registered request toward the data bus
    typedef struct packed {
        logic [XLEN-1:0]       address;
        logic [BUS_DATA_W-1:0] write_data;
        logic                  read_enable;
        logic                  write_enable;
    } bus_req_t;

    // register file write port
    typedef struct packed {
        logic                  enable;
        logic [REG_ADDR_W-1:0] address;
        word_t                 data;
    } rf_write_t;

endpackage

// File: logic/rv_regfile.sv
`timescale 1ns/1ns

module rv_regfile
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [REG_ADDR_W-1:0] rs2_addr_i,
    output word_t                 rs1_data_o,
    output word_t                 rs2_data_o,
    input  rf_write_t             rf_write_i
);

    word_t regs [32];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_write_i.enable && rf_write_i.address != '0) begin
            regs[rf_write_i.address] <= rf_write_i.data; // x0 never written
        end
    end

    // async read, x0 stays at its reset value
    assign rs1_data_o = regs[rs1_addr_i];
    assign rs2_data_o = regs[rs2_addr_i];

    x0_stays_zero: assert property (@(posedge clk) disable iff (!reset)
        rf_write_i.enable && rf_write_i.address == '0 |=> regs[0] == '0);

endmodule

// File: logic/rv_trap_unit.sv
`timescale 1ns/1ns

module rv_trap_unit
    import rv_core_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] interrupt_vector_i, // level from outside
    input  word_t      pc_i,
    input  logic       mret_i,
    output logic       trap_o,
    output word_t      mepc_o,
    output logic       interrupt_ack_o
);

    logic  mstatus_mie;   // mstatus bit 3
    logic  mstatus_mpie;  // mstatus bit 7
    word_t mepc;

    // only the external interrupt is taken, and only while enabled
    assign trap_o = (interrupt_vector_i == IRQ_EXTERNAL) && mstatus_mie;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_mie     <= 1'b1; // interrupts enabled out of reset
            mstatus_mpie    <= 1'b0;
            interrupt_ack_o <= 1'b0;
        end else begin
            interrupt_ack_o <= trap_o; // one cycle, mie drops at same edge
            if (trap_o) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (mret_i) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
        end
    end

    // return address
    always_ff @(posedge clk) begin
        if (trap_o) begin
            mepc <= pc_i;
        end
    end

    assign mepc_o = mepc;

    // the trap behind an ack moved mie into mpie and cleared mie
    ack_needs_mie: assert property (@(posedge clk) disable iff (!reset)
        interrupt_ack_o |-> $past(mstatus_mie) && mstatus_mpie && !mstatus_mie);

endmodule

// File: logic/rv_execute.sv
`timescale 1ns/1ns

module rv_execute
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  rv_instr_u             instruction_i,
    output word_t                 pc_o,
    output logic [REG_ADDR_W-1:0] rs1_addr_o,
    output logic [REG_ADDR_W-1:0] rs2_addr_o,
    input  word_t                 rs1_data_i,
    input  word_t                 rs2_data_i,
    output rf_write_t             rf_write_o,
    output bus_req_t              bus_req_o,
    input  logic [63:0]           bus_read_data_i, // low word only
    input  logic                  trap_i,
    input  word_t                 mepc_i,
    output logic                  mret_o
);

    rv_instr_u ir;          // fetch stage register
    word_t     pc;          // fetch pc, ir sits at pc - 4
    logic      bubble;      // ir is a wrong-path or refetched word
    logic [1:0] step;       // load/store sequence position
    logic      epc_adjust;  // trap cancelled a live ir, mepc is one past it
    bus_req_t  bus_req;

    opcode_e    opcode;
    logic [2:0] funct3;
    word_t      ir_pc;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;
    word_t      load_data;
    word_t      wr_data;
    logic       wr_en;
    logic       live;

    assign opcode = ir.r.opcode;
    assign funct3 = ir.r.funct3;
    assign ir_pc  = pc - 64'd4;
    assign imm_i  = imm_i_of(ir);
    assign imm_s  = imm_s_of(ir);
    assign imm_b  = imm_b_of(ir);
    assign imm_u  = imm_u_of(ir);
    assign imm_j  = imm_j_of(ir);
    assign live   = !bubble && !trap_i;  // trap kills the instruction in ir

    assign rs1_addr_o = ir.r.rs1;
    // ld merge reads back its own low word through port 2
    assign rs2_addr_o = (opcode == OP_LOAD) ? ir.r.rd : ir.r.rs2;

    assign mret_o = !bubble && (ir == MRET_WORD);

    // lane select from the held bus address
    assign ld_byte = bus_read_data_i[{bus_req.address[1:0], 3'b000} +: 8];
    assign ld_half = bus_read_data_i[{bus_req.address[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3)
            F3_LB:   load_data = {{56{ld_byte[7]}}, ld_byte};
            F3_LBU:  load_data = {56'b0, ld_byte};
            F3_LH:   load_data = {{48{ld_half[15]}}, ld_half};
            F3_LHU:  load_data = {48'b0, ld_half};
            F3_LW:   load_data = {{32{bus_read_data_i[31]}}, bus_read_data_i[31:0]};
            F3_LWU:  load_data = {32'b0, bus_read_data_i[31:0]};
            F3_LD: begin
                if (step == 2'd2) begin
                    load_data = {bus_read_data_i[31:0], rs2_data_i[31:0]}; // high half merge
                end else begin
                    load_data = {32'b0, bus_read_data_i[31:0]};
                end
            end
            default: load_data = '0;
        endcase
    end

    // writeback value
    always_comb begin
        wr_data = '0;
        wr_en   = 1'b1;
        case (opcode)
            OP_LUI:   wr_data = imm_u;
            OP_AUIPC: wr_data = ir_pc + imm_u;
            OP_IMM: begin
                case (funct3)
                    F3_ADD:  wr_data = rs1_data_i + imm_i;
                    F3_SLL:  wr_data = rs1_data_i << ir.i.imm[5:0];
                    F3_SRL:  wr_data = rs1_data_i >> ir.i.imm[5:0];
                    default: wr_en = 1'b0;
                endcase
            end
            OP_REG: begin
                case (funct3)
                    F3_ADD: begin
                        if (ir.r.funct7 == F7_SUB) begin
                            wr_data = rs1_data_i - rs2_data_i;
                        end else begin
                            wr_data = rs1_data_i + rs2_data_i;
                        end
                    end
                    F3_SLT:  wr_data = {63'b0, $signed(rs1_data_i) < $signed(rs2_data_i)};
                    default: wr_en = 1'b0;
                endcase
            end
            OP_JAL, OP_JALR: wr_data = pc;  // link = jump pc + 4
            OP_LOAD: begin
                wr_data = load_data;
                wr_en   = (step != 2'd0);   // nothing on the issue cycle
            end
            default: wr_en = 1'b0;
        endcase
    end

    assign rf_write_o = '{enable: live && wr_en, address: ir.r.rd, data: wr_data};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ir         <= NOP_WORD;
            pc         <= RAM_BASE;
            bubble     <= 1'b0;
            step       <= '0;
            epc_adjust <= 1'b0;
            bus_req    <= '0;
        end else begin
            ir                   <= instruction_i;
            pc                   <= pc + 64'd4;  // default, may be overridden
            bubble               <= 1'b0;
            bus_req.read_enable  <= 1'b0;
            bus_req.write_enable <= 1'b0;
            if (trap_i) begin
                pc         <= TRAP_VECTOR;
                bubble     <= 1'b1;
                step       <= '0;       // any load/store step restarts later
                epc_adjust <= !bubble;
            end else if (!bubble) begin
                case (opcode)
                    OP_LOAD: begin
                        if (step == 2'd0 || (step == 2'd1 && funct3 == F3_LD)) begin
                            if (step == 2'd0) begin
                                bus_req.address <= rs1_data_i + imm_i;
                            end else begin
                                bus_req.address <= bus_req.address + 64'd4; // ld high word
                            end
                            bus_req.read_enable <= 1'b1;
                            pc     <= ir_pc;    // refetch self behind the bubble
                            bubble <= 1'b1;
                            step   <= step + 2'd1;
                        end else begin
                            step <= '0;
                        end
                    end
                    OP_STORE: begin
                        bus_req.write_enable <= (funct3 == F3_SW) || (funct3 == F3_SD);
                        if (funct3 == F3_SD && step != 2'd0) begin
                            bus_req.address    <= rs1_data_i + imm_s + 64'd4;
                            bus_req.write_data <= rs2_data_i[63:32];
                            step               <= '0;
                        end else begin
                            bus_req.address    <= rs1_data_i + imm_s;
                            bus_req.write_data <= rs2_data_i[31:0];
                        end
                        if (funct3 == F3_SD && step == 2'd0) begin
                            pc     <= ir_pc;    // second pass writes the high word
                            bubble <= 1'b1;
                            step   <= 2'd1;
                        end
                    end
                    OP_JAL: begin
                        pc     <= ir_pc + imm_j;
                        bubble <= 1'b1;
                    end
                    OP_JALR: begin
                        pc     <= (rs1_data_i + imm_i) & ~64'd1;
                        bubble <= 1'b1;
                    end
                    OP_BRANCH: begin
                        if (funct3 == F3_BEQ && rs1_data_i == rs2_data_i) begin
                            pc     <= ir_pc + imm_b;
                            bubble <= 1'b1;
                        end
                    end
                    OP_SYSTEM: begin
                        if (mret_o) begin
                            pc     <= mepc_i - (epc_adjust ? 64'd4 : 64'd0);
                            bubble <= 1'b1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    assign pc_o      = pc;
    assign bus_req_o = bus_req;

    rd_wr_exclusive: assert property (@(posedge clk) disable iff (!reset)
        !(bus_req_o.read_enable && bus_req_o.write_enable));

    // the cycle after a read issue is always a bubble with no writeback
    no_wb_in_bubble: assert property (@(posedge clk) disable iff (!reset)
        bus_req_o.read_enable |-> bubble && !rf_write_o.enable);

endmodule

// File: logic/rv64_core.sv
`timescale 1ns/1ns

module rv64_core
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  rv_instr_u   instruction_i,      // comb from imem at pc_o
    output word_t       pc_o,
    output bus_req_t    bus_req_o,
    input  logic [63:0] bus_read_data_i,
    input  logic [3:0]  interrupt_vector_i,
    output logic        interrupt_ack_o
);

    logic [REG_ADDR_W-1:0] rs1_addr;
    logic [REG_ADDR_W-1:0] rs2_addr;
    word_t                 rs1_data;
    word_t                 rs2_data;
    rf_write_t             rf_write;
    logic                  trap;
    logic                  mret;
    word_t                 mepc;

    rv_execute u_execute (
        .clk             (clk),
        .reset           (reset),
        .instruction_i   (instruction_i),
        .pc_o            (pc_o),
        .rs1_addr_o      (rs1_addr),
        .rs2_addr_o      (rs2_addr),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (rs2_data),
        .rf_write_o      (rf_write),
        .bus_req_o       (bus_req_o),
        .bus_read_data_i (bus_read_data_i),
        .trap_i          (trap),
        .mepc_i          (mepc),
        .mret_o          (mret)
    );

    rv_regfile u_regfile (
        .clk        (clk),
        .reset      (reset),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .rf_write_i (rf_write)
    );

    // pc_o is the fetch pc, saved as mepc when the trap is taken
    rv_trap_unit u_trap_unit (
        .clk                (clk),
        .reset              (reset),
        .interrupt_vector_i (interrupt_vector_i),
        .pc_i               (pc_o),
        .mret_i             (mret),
        .trap_o             (trap),
        .mepc_o             (mepc),
        .interrupt_ack_o    (interrupt_ack_o)
    );

endmodule

// File: include/rv_asm.svh
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

// instruction encoders for building test programs

function automatic logic [31:0] asm_r(input logic [6:0] f7, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP_REG};
endfunction

function automatic logic [31:0] asm_i(input rv_isa_pkg::opcode_e op, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [4:0] rs1,
                                      input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] asm_u(input rv_isa_pkg::opcode_e op, input logic [4:0] rd,
                                      input logic [19:0] imm);
    return {imm, rd, op};
endfunction

// store, f3 picks sw or sd
function automatic logic [31:0] asm_s(input logic [2:0] f3, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_isa_pkg::OP_STORE};
endfunction

// byte offsets, bit 0 dropped
function automatic logic [31:0] asm_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                        input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, rv_isa_pkg::F3_BEQ, off[4:1], off[11],
            rv_isa_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] asm_jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_isa_pkg::OP_JAL};
endfunction

function automatic logic [31:0] asm_jalr(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return asm_i(rv_isa_pkg::OP_JALR, 3'b000, rd, rs1, imm);
endfunction

function automatic logic [31:0] asm_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return asm_i(rv_isa_pkg::OP_IMM, rv_isa_pkg::F3_ADD, rd, rs1, imm);
endfunction

// shamt in imm[5:0], upper bits zero for the logical forms
function automatic logic [31:0] asm_shift(input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [4:0] rs1, input logic [5:0] shamt);
    return asm_i(rv_isa_pkg::OP_IMM, f3, rd, rs1, {6'b0, shamt});
endfunction

function automatic logic [31:0] asm_load(input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [4:0] rs1, input logic [11:0] imm);
    return asm_i(rv_isa_pkg::OP_LOAD, f3, rd, rs1, imm);
endfunction

`endif

// File: verif/rv64_core_tb.sv
`timescale 1ns/1ns

module rv64_core_tb
    import rv_isa_pkg::*;
    import rv_core_pkg::*;
();

`include "rv_asm.svh"

    localparam int ARITH_CYCLES = 120;
    localparam int LOAD_CYCLES  = 220;
    localparam int FLOW_CYCLES  = 70;
    localparam int STORE_CYCLES = 50;
    localparam int IRQ_CYCLES   = 100;
    localparam int ALL_CYCLES   = ARITH_CYCLES + LOAD_CYCLES + FLOW_CYCLES + STORE_CYCLES
                                  + IRQ_CYCLES;
    localparam logic [11:0] DONE_ADDR = 12'h7FC; // every program ends with a store here

    logic        clk;
    logic        reset;
    rv_instr_u   instr;
    word_t       pc;
    bus_req_t    bus_req;
    logic [63:0] rdata;
    logic [3:0]  irq;
    logic        ack;

    logic [31:0] rom [logic [63:0]];  // sparse instruction ROM
    logic [31:0] dmem [1024];         // 4 KiB data memory
    int          wr_count [logic [63:0]];
    int          ack_count;
    int          rd_count;            // read strobes since reset
    logic        saw_trap_fetch;
    word_t       emit_pc;

    function automatic logic [31:0] fetch_word(word_t a);
        return rom.exists(a) ? rom[a] : NOP_WORD;
    endfunction

    assign instr = fetch_word(pc);
    assign rdata = {32'b0, dmem[bus_req.address[11:2]]}; // comb, address held by the core

    rv64_core dut (
        .clk                (clk),
        .reset              (reset),
        .instruction_i      (instr),
        .pc_o               (pc),
        .bus_req_o          (bus_req),
        .bus_read_data_i    (rdata),
        .interrupt_vector_i (irq),
        .interrupt_ack_o    (ack)
    );

    always #50 clk = ~clk;

    function automatic int count_of(logic [63:0] a);
        return wr_count.exists(a) ? wr_count[a] : 0;
    endfunction

    // memory write port plus bus and trap monitors
    always @(posedge clk) begin
        if (bus_req.read_enable && bus_req.write_enable) begin
            $display("read and write strobes were high in the same cycle");
            $display("Test FAILED");
            $fatal(1, "bus protocol error");
        end
        if (bus_req.write_enable) begin
            dmem[bus_req.address[11:2]] = bus_req.write_data;
            wr_count[bus_req.address] = count_of(bus_req.address) + 1;
        end
        if (bus_req.read_enable) rd_count++;
        if (ack) ack_count++;
        if (pc == TRAP_VECTOR) saw_trap_fetch = 1'b1;
    end

    task automatic check_equal(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("Test FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic emit(input logic [31:0] w);
        rom[emit_pc] = w;
        emit_pc += 4;
    endtask

    task automatic start_program();
        rom.delete();
        emit_pc = RAM_BASE;
    endtask

    task automatic pulse_reset();
        reset = 1'b0;
        wr_count.delete();
        ack_count      = 0;
        rd_count       = 0;
        saw_trap_fetch = 1'b0;
        repeat (5) @(posedge clk);
        #1 reset = 1'b1;
    endtask

    // sampled on the falling edge, away from the registered outputs
    task automatic wait_write(input logic [11:0] a);
        do @(negedge clk); while (!(bus_req.write_enable && bus_req.address == 64'(a)));
    endtask

    task automatic run_to_done();
        wait_write(DONE_ADDR);
        @(posedge clk);
        #1;
    endtask

    function automatic logic [63:0] dword_at(logic [11:0] a);
        return {dmem[a[11:2] + 10'd1], dmem[a[11:2]]};
    endfunction

    // extension rules for each load width
    function automatic logic [63:0] load_ref(logic [2:0] f3, logic [11:0] a);
        logic [31:0] lo;
        logic [7:0]  b;
        logic [15:0] h;
        lo = dmem[a[11:2]];
        b  = lo[8*a[1:0] +: 8];
        h  = lo[16*a[1] +: 16];
        case (f3)
            F3_LB:   return {{56{b[7]}}, b};
            F3_LBU:  return {56'b0, b};
            F3_LH:   return {{48{h[15]}}, h};
            F3_LHU:  return {48'b0, h};
            F3_LW:   return {{32{lo[31]}}, lo};
            F3_LWU:  return {32'b0, lo};
            default: return dword_at(a);
        endcase
    endfunction

    task automatic arith_test();
        word_t x [11];
        word_t pa;
        start_program();
        emit(asm_u(OP_LUI, 5'd1, 20'h12345));
        emit(asm_u(OP_LUI, 5'd2, 20'hFEDCB));
        pa = emit_pc;
        emit(asm_u(OP_AUIPC, 5'd3, 20'h00001));
        emit(asm_addi(5'd4, 5'd1, 12'hFFB));      // -5
        emit(asm_shift(F3_SLL, 5'd5, 5'd2, 6'd12));
        emit(asm_shift(F3_SRL, 5'd6, 5'd2, 6'd20));
        emit(asm_r(7'b0, F3_ADD, 5'd7, 5'd1, 5'd2));
        emit(asm_r(F7_SUB, F3_ADD, 5'd8, 5'd1, 5'd2));
        emit(asm_r(7'b0, F3_SLT, 5'd9, 5'd2, 5'd1));
        emit(asm_r(7'b0, F3_SLT, 5'd10, 5'd1, 5'd2));
        emit(asm_addi(5'd0, 5'd1, 12'd5));        // x0 must stay zero
        for (int k = 0; k < 11; k++) emit(asm_s(F3_SD, 5'(k), 5'd0, 12'(12'h200 + 8*k)));
        emit(asm_s(F3_SW, 5'd0, 5'd0, DONE_ADDR));
        pulse_reset();
        run_to_done();
        x[0]  = '0;
        x[1]  = 64'h0000_0000_1234_5000;
        x[2]  = 64'hFFFF_FFFF_FEDC_B000;  // lui sign extends
        x[3]  = pa + 64'h1000;
        x[4]  = x[1] - 64'd5;
        x[5]  = x[2] << 12;
        x[6]  = x[2] >> 20;
        x[7]  = x[1] + x[2];
        x[8]  = x[1] - x[2];
        x[9]  = ($signed(x[2]) < $signed(x[1])) ? 64'd1 : 64'd0;
        x[10] = ($signed(x[1]) < $signed(x[2])) ? 64'd1 : 64'd0;
        for (int k = 0; k < 11; k++) check_equal("arith", x[k], dword_at(12'(12'h200 + 8*k)));
    endtask

    task automatic add_load(ref logic [2:0] f3q[$], ref logic [1:0] offq[$],
                            input logic [2:0] f3, input logic [1:0] off);
        f3q.push_back(f3);
        offq.push_back(off);
    endtask

    task automatic load_test();
        logic [2:0]  f3q [$];
        logic [1:0]  offq [$];
        logic [11:0] src;
        int          reads;
        for (int o = 0; o < 4; o++) begin
            add_load(f3q, offq, F3_LB, 2'(o));
            add_load(f3q, offq, F3_LBU, 2'(o));
        end
        for (int o = 0; o < 4; o += 2) begin
            add_load(f3q, offq, F3_LH, 2'(o));
            add_load(f3q, offq, F3_LHU, 2'(o));
        end
        add_load(f3q, offq, F3_LW, 2'd0);
        add_load(f3q, offq, F3_LWU, 2'd0);
        add_load(f3q, offq, F3_LD, 2'd0);
        start_program();
        reads = 0;
        foreach (f3q[i]) begin
            src = 12'(12'h100 + 8*i + offq[i]);   // fresh random word per load
            emit(asm_load(f3q[i], 5'd5, 5'd0, src));
            emit(asm_s(F3_SD, 5'd5, 5'd0, 12'(12'h400 + 8*i)));
            reads += (f3q[i] == F3_LD) ? 2 : 1;   // ld reads two words
        end
        emit(asm_s(F3_SW, 5'd0, 5'd0, DONE_ADDR));
        pulse_reset();
        run_to_done();
        check_equal("read strobes", 64'(reads), 64'(rd_count));
        foreach (f3q[i]) begin
            src = 12'(12'h100 + 8*i + offq[i]);
            check_equal("load", load_ref(f3q[i], src), dword_at(12'(12'h400 + 8*i)));
        end
    endtask

    task automatic flow_test();
        word_t pj;
        word_t pa;
        start_program();
        emit(asm_addi(5'd1, 5'd0, 12'h011));      // marker value
        pj = emit_pc;
        emit(asm_jal(5'd5, 21'd8));
        emit(asm_s(F3_SW, 5'd1, 5'd0, 12'h500));  // jal shadow
        emit(asm_s(F3_SD, 5'd5, 5'd0, 12'h508));
        pa = emit_pc;
        emit(asm_u(OP_AUIPC, 5'd6, 20'h0));
        emit(asm_jalr(5'd7, 5'd6, 12'd12));
        emit(asm_s(F3_SW, 5'd1, 5'd0, 12'h510));  // jalr shadow
        emit(asm_s(F3_SD, 5'd7, 5'd0, 12'h518));
        emit(asm_beq(5'd0, 5'd0, 13'd8));          // taken
        emit(asm_s(F3_SW, 5'd1, 5'd0, 12'h520));
        emit(asm_beq(5'd1, 5'd0, 13'd8));          // not taken
        emit(asm_s(F3_SW, 5'd1, 5'd0, 12'h528));
        emit(asm_s(F3_SW, 5'd0, 5'd0, DONE_ADDR));
        pulse_reset();
        run_to_done();
        check_equal("jal shadow", 0, count_of(64'h500));
        check_equal("jal link", pj + 64'd4, dword_at(12'h508));
        check_equal("jalr shadow", 0, count_of(64'h510));
        check_equal("jalr link", pa + 64'd8, dword_at(12'h518));
        check_equal("beq taken", 0, count_of(64'h520));
        check_equal("beq untaken", 64'h11, {32'b0, dmem[12'h528 >> 2]});
    endtask

    task automatic store_test();
        start_program();
        emit(asm_addi(5'd1, 5'd0, 12'h3C5));
        emit(asm_u(OP_LUI, 5'd2, 20'hABCDE));
        emit(asm_addi(5'd2, 5'd2, 12'h123));
        emit(asm_s(F3_SW, 5'd1, 5'd0, 12'h600));
        emit(asm_s(F3_SD, 5'd2, 5'd0, 12'h608));
        emit(asm_s(F3_SW, 5'd0, 5'd0, DONE_ADDR));
        pulse_reset();
        run_to_done();
        check_equal("sw count", 1, count_of(64'h600));
        check_equal("sw gap", 0, count_of(64'h604));
        check_equal("sd low count", 1, count_of(64'h608));
        check_equal("sd high count", 1, count_of(64'h60C));
        check_equal("sw data", 64'h3C5, {32'b0, dmem[12'h600 >> 2]});
        check_equal("sd data", 64'hFFFF_FFFF_ABCD_E123, dword_at(12'h608));
    endtask

    task automatic irq_test();
        start_program();
        for (int k = 0; k < 8; k++) begin
            emit(asm_addi(5'd1, 5'd0, 12'(k + 1)));
            emit(asm_s(F3_SW, 5'd1, 5'd0, 12'(12'h700 + 4*k)));
        end
        emit(asm_s(F3_SW, 5'd0, 5'd0, DONE_ADDR));
        emit_pc = TRAP_VECTOR;                      // handler
        emit(asm_addi(5'd11, 5'd0, 12'h05A));
        emit(asm_s(F3_SW, 5'd11, 5'd0, 12'h6F0));
        repeat (8) emit(NOP_WORD);
        emit(MRET_WORD);
        pulse_reset();
        repeat (4) @(posedge clk);
        #1 irq = IRQ_EXTERNAL;
        wait_write(12'h6F0);
        repeat (3) @(posedge clk);                  // still held inside the handler
        #1 irq = 4'd0;
        run_to_done();
        check_equal("ack pulses", 1, ack_count);
        check_equal("trap fetch", 1, saw_trap_fetch);
        check_equal("handler store", 64'h5A, {32'b0, dmem[12'h6F0 >> 2]});
        for (int k = 0; k < 8; k++) begin
            check_equal("main store", 64'(k + 1), {32'b0, dmem[(12'h700 + 4*k) >> 2]});
        end
    endtask

    initial begin
        clk   = 1'b0;
        reset = 1'b0;
        irq   = 4'd0;
        void'($urandom(32'hc49f_4052));
        foreach (dmem[i]) dmem[i] = $urandom();
        @(posedge clk);
        #1;
        arith_test();
        load_test();
        flow_test();
        store_test();
        irq_test();
        $display("Test OK");
        $finish;
    end

    initial begin
        #(ALL_CYCLES * 2 * 100);
        $display("simulation ran past its cycle budget");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule

// File: files.f
+incdir+include
logic/rv_isa_pkg.sv
logic/rv_core_pkg.sv
logic/rv_regfile.sv
logic/rv_trap_unit.sv
logic/rv_execute.sv
logic/rv64_core.sv
verif/rv64_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, exit status reports pass or fail
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
    --top-module rv64_core_tb -f files.f -o rv64_core_sim &&
./obj_dir/rv64_core_sim || {
    echo "simulation failed"
    exit 1
}
